// ==== dv/exec_stimulus.txt ====
// Record count, then one operation per line, all in hex:
// op use_imm scale a b imm pc expected_value expected_dbz
2d
00 0 0 7fffffffffffffff 1 0 0 8000000000000000 0
01 0 0 5 7 0 0 fffffffffffffffe 0
00 1 0 100 dead 23 0 123 0
02 0 0 f0f0 ff00 0 0 f000 0
03 0 0 f0f0 ff00 0 0 fff0 0
04 1 0 f0f0 1234 ff00 0 ff0 0
05 0 0 f0f0 ff00 0 0 f0 0
06 0 0 f0f0 ff00 0 0 ffffffffffff0fff 0
07 0 0 f0f0 ff00 0 0 ffffffffffff000f 0
08 0 0 f0f0 ff00 0 0 fffffffffffff00f 0
09 0 0 f0f0 ff00 0 0 fffffffffffff0ff 0
0a 0 0 ffffffffffffffff 1 0 0 ffffffffffffffff 0
0b 0 0 ffffffffffffffff 1 0 0 1 0
0a 0 0 5 5 0 0 0 0
0e 0 0 ffffffffffffffff 1 0 0 1 0
10 0 0 ffffffffffffffff 1 0 0 0 0
0c 0 0 5 5 0 0 1 0
0d 0 0 5 5 0 0 0 0
0f 0 0 8000000000000000 8000000000000000 0 0 1 0
11 0 0 8000000000000000 7fffffffffffffff 0 0 0 0
12 0 0 8000000000000001 1 0 0 2 0
12 0 0 8000000000000001 40 0 0 8000000000000001 0
13 0 0 8000000000000001 3f 0 0 1 0
14 0 0 8000000000000001 1 0 0 c000000000000000 0
14 0 0 8000000000000001 7f 0 0 ffffffffffffffff 0
15 0 0 8000000000000001 1 0 0 3 0
16 0 0 8000000000000001 0 0 0 8000000000000001 0
16 0 0 8000000000000001 41 0 0 c000000000000000 0
17 0 3 1000 3 20 0 1038 0
18 0 0 0 0 0 80001000 80001005 0
19 0 0 fffffffffffffffd 7 0 0 ffffffffffffffeb 0
1b 0 0 fffffffffffffffd 7 0 0 ffffffffffffffff 0
1a 0 0 fffffffffffffffd 7 0 0 ffffffffffffffeb 0
1c 0 0 fffffffffffffffd 7 0 0 6 0
1c 0 0 ffffffffffffffff ffffffffffffffff 0 0 fffffffffffffffe 0
1a 0 0 ffffffffffffffff ffffffffffffffff 0 0 1 0
1d 0 0 fffffffffffffff9 2 0 0 fffffffffffffffd 0
1f 0 0 fffffffffffffff9 2 0 0 ffffffffffffffff 0
1d 0 0 7 fffffffffffffffe 0 0 fffffffffffffffd 0
1f 0 0 7 fffffffffffffffe 0 0 1 0
1e 0 0 fffffffffffffff9 2 0 0 7ffffffffffffffc 0
20 0 0 fffffffffffffff9 2 0 0 1 0
1d 0 0 1234 0 0 0 ffffffffffffffff 1
20 0 0 1234 0 0 0 1234 1
1e 1 0 99 5 0 0 ffffffffffffffff 1

// ==== dv/exec_unit_tb.sv ====
// Execution unit testbench
module exec_unit_tb;

	timeunit 1ns;
	timeprecision 100ps;

	logic clk;
	logic rst;
	logic op_req;
	exec_pkg::exec_op_t op;
	logic op_ack;
	logic res_req;
	exec_pkg::exec_res_t res;
	logic res_ack;

	// Word 0 is the record count, then nine words per record
	logic [63:0] stim_mem [0:1023];
	int num_records;
	int timeout_limit;
	int cycle_count = 0;
	logic [15:0] lfsr_state = 16'd37756;

	// Handshake monitor state
	logic op_ack_q;
	logic res_ack_q;
	logic in_flight;

	exec_unit exec_unit_inst (
		.clk     (clk),
		.rst     (rst),
		.op_req  (op_req),
		.op      (op),
		.op_ack  (op_ack),
		.res_req (res_req),
		.res     (res),
		.res_ack (res_ack)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ====================
	// Helpers
	// ====================

	task stop_with_failure();
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input int rec, input string name,
		input exec_pkg::value_t got, input exec_pkg::value_t exp);
		if (got !== exp)
		begin
			$display("Error: %s in record %0d is %h, expected %h", name, rec, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_dbz(input int rec, input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Error: %s in record %0d is %h, expected %h", name, rec, got, exp);
			stop_with_failure();
		end
	endtask

	// Taps 16, 14, 13, 11 give a maximal length sequence
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step for each of the four delay bits
	function automatic logic [3:0] draw_delay();
		logic [3:0] bits;
		bits = '0;
		for (int i = 0; i < 4; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[2:0], lfsr_state[0]};
		end
		return bits;
	endfunction

	// Operation fields of one record as they go onto the input handshake
	function automatic exec_pkg::exec_op_t record_op(input int rec);
		int base;
		exec_pkg::exec_op_t rec_op;
		base = 1 + rec * 9;
		rec_op.op = exec_pkg::op_t'(stim_mem[base][5:0]);
		rec_op.use_imm = stim_mem[base + 1][0];
		rec_op.scale = stim_mem[base + 2][1:0];
		rec_op.a = stim_mem[base + 3];
		rec_op.b = stim_mem[base + 4];
		rec_op.imm = stim_mem[base + 5];
		rec_op.pc = stim_mem[base + 6][31:0];
		return rec_op;
	endfunction

	// ====================
	// One operation
	// ====================

	task automatic run_record(input int rec);
		int base;
		exec_pkg::exec_op_t next_op;
		exec_pkg::value_t exp_value;
		logic exp_dbz;
		logic [3:0] delay;
		base = 1 + rec * 9;
		next_op = record_op(rec);
		exp_value = stim_mem[base + 7];
		exp_dbz = stim_mem[base + 8][0];

		// Input handshake
		@(posedge clk);
		op <= next_op;
		op_req <= 1'b1;
		@(negedge clk);
		while (!op_ack)
			@(negedge clk);
		@(posedge clk);
		op_req <= 1'b0;
		@(negedge clk);
		while (op_ack)
			@(negedge clk);

		// Fast units can already be requesting by now
		while (!res_req)
			@(negedge clk);
		check_value(rec, "res.value", res.value, exp_value);
		check_dbz(rec, "res.dbz", res.dbz, exp_dbz);

		// The next operation waits on the input while this result is still held
		if (rec + 1 < num_records)
		begin
			@(posedge clk);
			op <= record_op(rec + 1);
			op_req <= 1'b1;
		end

		// Result has to hold for as long as the ack is held back
		delay = draw_delay();
		repeat (delay)
		begin
			@(negedge clk);
			if (!res_req)
			begin
				$display("res_req dropped in record %0d before res_ack was raised", rec);
				stop_with_failure();
			end
			check_value(rec, "res.value", res.value, exp_value);
			check_dbz(rec, "res.dbz", res.dbz, exp_dbz);
		end

		@(posedge clk);
		res_ack <= 1'b1;
		@(negedge clk);
		while (res_req)
			@(negedge clk);
		@(posedge clk);
		res_ack <= 1'b0;
	endtask

	// ====================
	// Main sequence
	// ====================

	initial
	begin
		rst <= 1'b1;
		op_req <= 1'b0;
		op <= '0;
		res_ack <= 1'b0;
		$readmemh("dv/exec_stimulus.txt", stim_mem);
		num_records = int'(stim_mem[0][31:0]);
		if (num_records < 1 || 1 + num_records * 9 > $size(stim_mem))
		begin
			$display("Stimulus file holds a record count of %0d, which does not fit", num_records);
			stop_with_failure();
		end
		// Divide is the slowest path at about 80 cycles with the longest ack delay
		timeout_limit = num_records * 100 + 20;
		repeat (3)
			@(posedge clk);
		rst <= 1'b0;
		for (int rec = 0; rec < num_records; rec++)
			run_record(rec);
		$display("TESTBENCH PASSED");
		$finish;
	end

	// A new op_ack is only allowed once the previous res_ack has fallen
	always @(negedge clk)
	begin
		if (rst)
			in_flight <= 1'b0;
		else
		begin
			if (op_ack && !op_ack_q)
			begin
				if (in_flight)
				begin
					$display("op_ack rose before the previous result handshake had finished");
					stop_with_failure();
				end
				in_flight <= 1'b1;
			end
			else if (!res_ack && res_ack_q)
				in_flight <= 1'b0;
		end
		op_ack_q <= op_ack;
		res_ack_q <= res_ack;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit)
		begin
			$display("Timeout after %0d cycles, not every record completed", cycle_count);
			stop_with_failure();
		end
	end

endmodule

// ==== flist.f ====
hdl/exec_pkg.sv
hdl/exec_issue.sv
hdl/exec_alu.sv
hdl/exec_mul.sv
hdl/exec_div.sv
hdl/exec_result.sv
hdl/exec_unit.sv
dv/exec_unit_tb.sv

// ==== hdl/exec_alu.sv ====
// Single-cycle ALU
module exec_alu (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  exec_pkg::exec_op_t  issued,
	output logic                valid,
	output exec_pkg::exec_res_t res
);

	exec_pkg::value_t a;
	exec_pkg::value_t b;
	exec_pkg::value_t cmp_s;
	exec_pkg::value_t cmp_u;
	exec_pkg::value_t alu_out;
	logic [5:0] shamt;
	// Complement of the shift amount for the wrap-around half of a rotate
	logic [6:0] rot_amt;
	logic lt_s;
	logic lt_u;
	logic eq;

	assign a = issued.a;
	assign b = issued.b;

	// Only the low six bits of b count as a shift amount
	assign shamt = b[5:0];
	assign rot_amt = 7'd64 - {1'b0, shamt};

	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;
	assign eq = (a == b);

	// Three-way compare gives -1, 0 or +1
	assign cmp_s = lt_s ? '1 : (eq ? '0 : exec_pkg::value_t'(1));
	assign cmp_u = lt_u ? '1 : (eq ? '0 : exec_pkg::value_t'(1));

	// ====================
	// Result select
	// ====================

	always_comb
	begin
		case (issued.op)
			exec_pkg::op_add:   alu_out = a + b;
			exec_pkg::op_sub:   alu_out = a - b;
			exec_pkg::op_and:   alu_out = a & b;
			exec_pkg::op_or:    alu_out = a | b;
			exec_pkg::op_xor:   alu_out = a ^ b;
			exec_pkg::op_andc:  alu_out = a & ~b;
			exec_pkg::op_nand:  alu_out = ~(a & b);
			exec_pkg::op_nor:   alu_out = ~(a | b);
			exec_pkg::op_xnor:  alu_out = ~(a ^ b);
			exec_pkg::op_orc:   alu_out = a | ~b;
			exec_pkg::op_cmp:   alu_out = cmp_s;
			exec_pkg::op_cmpu:  alu_out = cmp_u;
			// Set ops return a single flag in bit zero
			exec_pkg::op_seq:   alu_out = {63'd0, eq};
			exec_pkg::op_sne:   alu_out = {63'd0, !eq};
			exec_pkg::op_slt:   alu_out = {63'd0, lt_s};
			exec_pkg::op_sle:   alu_out = {63'd0, lt_s || eq};
			exec_pkg::op_sltu:  alu_out = {63'd0, lt_u};
			exec_pkg::op_sleu:  alu_out = {63'd0, lt_u || eq};
			exec_pkg::op_shl:   alu_out = a << shamt;
			exec_pkg::op_lsr:   alu_out = a >> shamt;
			// Arithmetic shift copies the sign bit in from the top
			exec_pkg::op_asr:   alu_out = $signed(a) >>> shamt;
			// A shift by 64 gives zero, so a zero rotate leaves a as it is
			exec_pkg::op_rol:   alu_out = (a << shamt) | (a >> rot_amt);
			exec_pkg::op_ror:   alu_out = (a >> shamt) | (a << rot_amt);
			// Scaled index address: base plus displacement plus index times 1, 2, 4 or 8
			exec_pkg::op_lda:   alu_out = a + issued.imm + (b << issued.scale);
			// Return address skips the five-byte call instruction
			exec_pkg::op_link:  alu_out = {32'd0, issued.pc + 32'd5};
			default:            alu_out = '0;
		endcase
	end

	// Output register, loaded on the start pulse
	always_ff @(posedge clk)
	begin
		if (rst)
			valid <= 1'b0;
		else
			valid <= start;
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			res.value <= alu_out;
			res.dbz <= 1'b0;
		end
	end

endmodule

// ==== hdl/exec_div.sv ====
// Iterative divider
module exec_div (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  exec_pkg::exec_op_t  issued,
	output logic                valid,
	output exec_pkg::exec_res_t res
);

	typedef enum logic [1:0] {st_idle, st_run, st_done} state_t;

	state_t state;
	logic [6:0] count;
	logic sgn;
	logic is_rem;
	logic b_zero;
	exec_pkg::value_t abs_a;
	exec_pkg::value_t abs_b;
	// Quotient bits shift in from the bottom as dividend bits shift out the top
	exec_pkg::value_t quo;
	exec_pkg::value_t rem;
	exec_pkg::value_t dvs;
	logic [64:0] rem_sh;
	logic [64:0] diff;
	logic rem_op;
	logic neg_q;
	logic neg_r;
	logic dbz;

	assign sgn = (issued.op == exec_pkg::op_div) || (issued.op == exec_pkg::op_mod);
	assign is_rem = (issued.op == exec_pkg::op_mod) || (issued.op == exec_pkg::op_modu);
	assign b_zero = (issued.b == '0);
	assign abs_a = (sgn && issued.a[63]) ? -issued.a : issued.a;
	assign abs_b = (sgn && issued.b[63]) ? -issued.b : issued.b;

	// One restoring step, a negative trial difference keeps the shifted remainder
	assign rem_sh = {rem, quo[63]};
	assign diff = rem_sh - {1'b0, dvs};

	// ====================
	// Control FSM
	// ====================

	always_ff @(posedge clk)
	begin
		valid <= 1'b0;
		if (rst)
		begin
			state <= st_idle;
			count <= '0;
		end
		else
		begin
			case (state)
				st_idle:
					if (start)
					begin
						count <= '0;
						// A zero divisor goes straight to the result
						state <= b_zero ? st_done : st_run;
					end
				st_run:
				begin
					count <= count + 7'd1;
					if (count == 7'(exec_pkg::DIV_STEPS - 1))
						state <= st_done;
				end
				st_done:
				begin
					valid <= 1'b1;
					state <= st_idle;
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	// Datapath registers
	always_ff @(posedge clk)
	begin
		case (state)
			st_idle:
				if (start)
				begin
					rem_op <= is_rem;
					dbz <= b_zero;
					if (b_zero)
					begin
						quo <= '1;
						rem <= issued.a;
						neg_q <= 1'b0;
						neg_r <= 1'b0;
					end
					else
					begin
						quo <= abs_a;
						rem <= '0;
						dvs <= abs_b;
						neg_q <= sgn & (issued.a[63] ^ issued.b[63]);
						// Remainder follows the dividend
						neg_r <= sgn & issued.a[63];
					end
				end
			st_run:
			begin
				quo <= {quo[62:0], ~diff[64]};
				rem <= diff[64] ? rem_sh[63:0] : diff[63:0];
			end
			st_done:
			begin
				if (rem_op)
					res.value <= neg_r ? -rem : rem;
				else
					res.value <= neg_q ? -quo : quo;
				res.dbz <= dbz;
			end
			default:
			begin
			end
		endcase
	end

	// Issue holds off new work, so no start lands mid-division
	assert property (@(posedge clk) disable iff (rst) (state == st_run) |-> !start);

endmodule

// ==== hdl/exec_issue.sv ====
// Operation issue stage
module exec_issue (
	input  logic                clk,
	input  logic                rst,
	input  logic                op_req,
	input  exec_pkg::exec_op_t  op,
	output logic                op_ack,
	input  logic                retire,
	output exec_pkg::exec_op_t  issued,
	output logic                alu_start,
	output logic                mul_start,
	output logic                div_start
);

	typedef enum logic [1:0] {st_idle, st_acked, st_busy} state_t;

	state_t state;
	exec_pkg::unit_t unit_sel;
	exec_pkg::exec_op_t op_sel;
	// Retire can overtake the falling edge of op_req when the outside is slow to drop it
	logic retired;

	// Operand select and unit decode straight from the input operation
	always_comb
	begin
		op_sel = op;
		if (op.use_imm)
			op_sel.b = op.imm;
		case (op.op)
			exec_pkg::op_mul, exec_pkg::op_mulu, exec_pkg::op_mulh, exec_pkg::op_muluh:
				unit_sel = exec_pkg::unit_mul;
			exec_pkg::op_div, exec_pkg::op_divu, exec_pkg::op_mod, exec_pkg::op_modu:
				unit_sel = exec_pkg::unit_div;
			default:
				unit_sel = exec_pkg::unit_alu;
		endcase
	end

	// ====================
	// Handshake FSM
	// ====================

	always_ff @(posedge clk)
	begin
		alu_start <= 1'b0;
		mul_start <= 1'b0;
		div_start <= 1'b0;
		if (rst)
		begin
			state <= st_idle;
			op_ack <= 1'b0;
			retired <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
					if (op_req)
					begin
						// Ack and start leave on the same edge
						op_ack <= 1'b1;
						retired <= 1'b0;
						alu_start <= (unit_sel == exec_pkg::unit_alu);
						mul_start <= (unit_sel == exec_pkg::unit_mul);
						div_start <= (unit_sel == exec_pkg::unit_div);
						state <= st_acked;
					end
				st_acked:
				begin
					if (retire)
						retired <= 1'b1;
					if (!op_req)
					begin
						op_ack <= 1'b0;
						state <= (retired || retire) ? st_idle : st_busy;
					end
				end
				st_busy:
					// Hold off the next request until the result has been taken
					if (retire)
						state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	// Captured operation, only loaded when a new request is accepted
	always_ff @(posedge clk)
	begin
		if (state == st_idle && op_req)
			issued <= op_sel;
	end

	// No new acknowledge while an operation is still outstanding
	assert property (@(posedge clk) disable iff (rst) (state == st_busy) |=> !$rose(op_ack));

	// Only one unit is started per operation
	assert property (@(posedge clk) disable iff (rst) $onehot0({alu_start, mul_start, div_start}));

endmodule

// ==== hdl/exec_mul.sv ====
// Pipelined multiplier
module exec_mul (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  exec_pkg::exec_op_t  issued,
	output logic                valid,
	output exec_pkg::exec_res_t res
);

	logic sgn;
	logic [127:0] ext_a;
	logic [127:0] ext_b;
	logic [127:0] prod1;
	logic [127:0] prod2;
	// Half select travels alongside the product
	logic hi1;
	logic hi2;
	logic v1;
	logic v2;

	assign sgn = (issued.op == exec_pkg::op_mul) || (issued.op == exec_pkg::op_mulh);

	// Sign-extending to 128 bits lets one unsigned multiply cover both signed forms
	assign ext_a = {{64{sgn & issued.a[63]}}, issued.a};
	assign ext_b = {{64{sgn & issued.b[63]}}, issued.b};

	// Valid chain matches the three product registers
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			valid <= 1'b0;
		end
		else
		begin
			v1 <= start;
			v2 <= v1;
			valid <= v2;
		end
	end

	always_ff @(posedge clk)
	begin
		prod1 <= ext_a * ext_b;
		hi1 <= (issued.op == exec_pkg::op_mulh) || (issued.op == exec_pkg::op_muluh);
		prod2 <= prod1;
		hi2 <= hi1;
		// Last stage picks the half
		res.value <= hi2 ? prod2[127:64] : prod2[63:0];
		res.dbz <= 1'b0;
	end

endmodule

// ==== hdl/exec_pkg.sv ====
// Execution unit definitions
package exec_pkg;

	// ====================
	// Word types
	// ====================

	// Operand and result word
	typedef logic [63:0] value_t;
	// Program counter
	typedef logic [31:0] addr_t;

	// ====================
	// Operations
	// ====================

	// Operations arrive already decoded, the encoding is fixed so stimulus can name them
	typedef enum logic [5:0] {
		op_add   = 6'd0,
		op_sub   = 6'd1,
		op_and   = 6'd2,
		op_or    = 6'd3,
		op_xor   = 6'd4,
		op_andc  = 6'd5,
		op_nand  = 6'd6,
		op_nor   = 6'd7,
		op_xnor  = 6'd8,
		op_orc   = 6'd9,
		op_cmp   = 6'd10,
		op_cmpu  = 6'd11,
		op_seq   = 6'd12,
		op_sne   = 6'd13,
		op_slt   = 6'd14,
		op_sle   = 6'd15,
		op_sltu  = 6'd16,
		op_sleu  = 6'd17,
		op_shl   = 6'd18,
		op_lsr   = 6'd19,
		op_asr   = 6'd20,
		op_rol   = 6'd21,
		op_ror   = 6'd22,
		op_lda   = 6'd23,
		op_link  = 6'd24,
		op_mul   = 6'd25,
		op_mulu  = 6'd26,
		op_mulh  = 6'd27,
		op_muluh = 6'd28,
		op_div   = 6'd29,
		op_divu  = 6'd30,
		op_mod   = 6'd31,
		op_modu  = 6'd32
	} op_t;

	// Which execution unit runs an operation
	typedef enum logic [1:0] {
		unit_alu = 2'd0,
		unit_mul = 2'd1,
		unit_div = 2'd2
	} unit_t;

	// Operation as presented on the input handshake
	typedef struct packed {
		op_t         op;
		logic        use_imm;
		logic [1:0]  scale;
		value_t      a;
		value_t      b;
		value_t      imm;
		addr_t       pc;
	} exec_op_t;

	// Result as presented on the output handshake
	typedef struct packed {
		value_t value;
		logic   dbz;
	} exec_res_t;

	// One quotient bit per divider iteration
	localparam int DIV_STEPS = 64;

endpackage

// ==== hdl/exec_result.sv ====
// Result stage
module exec_result (
	input  logic                clk,
	input  logic                rst,
	input  logic                alu_valid,
	input  logic                mul_valid,
	input  logic                div_valid,
	input  exec_pkg::exec_res_t alu_res,
	input  exec_pkg::exec_res_t mul_res,
	input  exec_pkg::exec_res_t div_res,
	output logic                res_req,
	output exec_pkg::exec_res_t res,
	input  logic                res_ack,
	output logic                retire
);

	typedef enum logic [1:0] {st_idle, st_req, st_wait_low} state_t;

	state_t state;

	// ====================
	// Output handshake
	// ====================

	always_ff @(posedge clk)
	begin
		retire <= 1'b0;
		if (rst)
		begin
			state <= st_idle;
			res_req <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
					if (alu_valid || mul_valid || div_valid)
					begin
						res_req <= 1'b1;
						state <= st_req;
					end
				st_req:
					// Result has been taken once ack is seen
					if (res_ack)
					begin
						res_req <= 1'b0;
						state <= st_wait_low;
					end
				st_wait_low:
					// Handshake is over when ack drops, let issue take the next op
					if (!res_ack)
					begin
						retire <= 1'b1;
						state <= st_idle;
					end
				default:
					state <= st_idle;
			endcase
		end
	end

	// Result holds until the next completion, which cannot come before retire
	always_ff @(posedge clk)
	begin
		if (alu_valid)
			res <= alu_res;
		else if (mul_valid)
			res <= mul_res;
		else if (div_valid)
			res <= div_res;
	end

	// Only one unit completes per operation
	assert property (@(posedge clk) disable iff (rst) $onehot0({alu_valid, mul_valid, div_valid}));

endmodule

// ==== hdl/exec_unit.sv ====
// Integer execution unit
module exec_unit (
	input  logic                clk,
	input  logic                rst,
	input  logic                op_req,
	input  exec_pkg::exec_op_t  op,
	output logic                op_ack,
	output logic                res_req,
	output exec_pkg::exec_res_t res,
	input  logic                res_ack
);

	exec_pkg::exec_op_t issued;
	logic alu_start;
	logic mul_start;
	logic div_start;
	logic alu_valid;
	logic mul_valid;
	logic div_valid;
	exec_pkg::exec_res_t alu_res;
	exec_pkg::exec_res_t mul_res;
	exec_pkg::exec_res_t div_res;
	logic retire;

	// Issue stage feeds all three units the same operation
	exec_issue exec_issue_inst (
		.clk       (clk),
		.rst       (rst),
		.op_req    (op_req),
		.op        (op),
		.op_ack    (op_ack),
		.retire    (retire),
		.issued    (issued),
		.alu_start (alu_start),
		.mul_start (mul_start),
		.div_start (div_start)
	);

	exec_alu exec_alu_inst (
		.clk    (clk),
		.rst    (rst),
		.start  (alu_start),
		.issued (issued),
		.valid  (alu_valid),
		.res    (alu_res)
	);

	exec_mul exec_mul_inst (
		.clk    (clk),
		.rst    (rst),
		.start  (mul_start),
		.issued (issued),
		.valid  (mul_valid),
		.res    (mul_res)
	);

	exec_div exec_div_inst (
		.clk    (clk),
		.rst    (rst),
		.start  (div_start),
		.issued (issued),
		.valid  (div_valid),
		.res    (div_res)
	);

	// Result stage closes the loop back to issue through retire
	exec_result exec_result_inst (
		.clk       (clk),
		.rst       (rst),
		.alu_valid (alu_valid),
		.mul_valid (mul_valid),
		.div_valid (div_valid),
		.alu_res   (alu_res),
		.mul_res   (mul_res),
		.div_res   (div_res),
		.res_req   (res_req),
		.res       (res),
		.res_ack   (res_ack),
		.retire    (retire)
	);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execution unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module exec_unit_tb -f flist.f -o exec_unit_sim

# The simulator exits non-zero on a failure, so the pass message decides the result
output="$(./obj_dir/exec_unit_sim 2>&1)" || true
echo "$output"

if grep -q "TESTBENCH PASSED" <<< "$output"; then
	exit 0
else
	exit 1
fi
